// File: filelist.f
+incdir+include
design/sb_pkg.sv
design/sb_prio_select.sv
design/sb_entry_queue.sv
design/sb_clobber_map.sv
design/sb_operand_fwd.sv
design/scoreboard_top.sv
test/scoreboard_properties.sv
test/scoreboard_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= scoreboard_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/scoreboard_tb.sv
// self-checking testbench of the issue scoreboard
// drives random traffic on rising edges, compares against a queue model on falling edges
module scoreboard_tb
  import sb_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic clk_i, rst_ni, flush_i, flush_unissued_i, unresolved_branch_i;
  logic decoded_valid_i, decoded_ack_o, issue_valid_o, issue_ack_i, sb_full_o;
  fu_e decoded_fu_i;
  reg_addr_t decoded_rd_i, rs1_i, rs2_i;
  trans_id_t issue_trans_id_o;
  logic [1:0] wb_valid_i, commit_ack_i, commit_valid_o;
  trans_id_t [1:0] wb_trans_id_i, commit_trans_id_o;
  xlen_t [1:0] wb_data_i, commit_result_o;
  reg_addr_t [1:0] commit_rd_o;
  fu_e [31:0] rd_clobber_o;
  xlen_t rs1_o, rs2_o;
  logic rs1_valid_o, rs2_valid_o;

  // queue model
  logic m_issued [8];
  logic m_valid [8];
  fu_e m_fu [8];
  reg_addr_t m_rd [8];
  xlen_t m_result [8];
  int m_ip, m_cp, m_cnt, committed, errors;
  string cur_test;

  // stimulus intent that step applies
  logic auto_issue, auto_wb, auto_ack, auto_rs;
  logic s_dec_valid, s_branch, s_flush, s_flush_un;
  fu_e s_fu;
  reg_addr_t s_rd, s_rs1, s_rs2;
  logic [1:0] s_wb_valid, s_ack;
  trans_id_t [1:0] s_wb_id;
  xlen_t [1:0] s_wb_data;

  scoreboard_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------
  function automatic logic [32:0] expected_fwd(reg_addr_t rs);
    // write-back ports before completed entries and the lowest index wins
    for (int p = 0; p < 2; p++) begin
      if (wb_valid_i[p] && m_issued[wb_trans_id_i[p]] && m_rd[wb_trans_id_i[p]] == rs)
        return {rs != 0, wb_data_i[p]};
    end
    for (int e = 0; e < 8; e++) begin
      if (m_issued[e] && m_valid[e] && m_rd[e] == rs) return {rs != 0, m_result[e]};
    end
    return 33'd0;
  endfunction

  function automatic fu_e expected_clobber(int r);
    for (int e = 0; e < 8; e++) begin
      if (r != 0 && m_issued[e] && m_rd[e] == reg_addr_t'(r)) return m_fu[e];
    end
    return NONE;
  endfunction

  // a nonzero register with no writer in flight
  function automatic reg_addr_t free_rd();
    int r;
    logic busy;
    r = $urandom_range(1, 31);
    for (int n = 0; n < 32; n++) begin
      busy = 1'b0;
      for (int e = 0; e < 8; e++) busy |= m_issued[e] && m_rd[e] == reg_addr_t'(r);
      if (!busy) return reg_addr_t'(r);
      r = (r % 31) + 1;
    end
    return '0;
  endfunction

  // applies the inputs of the cycle that just ended in order of precedence
  task automatic model_update();
    logic oi [8];
    fu_e ofu [8];
    logic alloc;
    int nacks;
    oi = m_issued;
    ofu = m_fu;
    alloc = decoded_valid_i && issue_ack_i && m_cnt < 8 && !flush_unissued_i;
    nacks = commit_ack_i[0] + commit_ack_i[1];
    if (alloc) begin
      m_issued[m_ip] = 1'b1;
      m_valid[m_ip] = 1'b0;
      m_fu[m_ip] = decoded_fu_i;
      m_rd[m_ip] = decoded_rd_i;
    end
    for (int p = 0; p < 2; p++) begin
      if (wb_valid_i[p] && oi[wb_trans_id_i[p]]) begin
        m_valid[wb_trans_id_i[p]] = 1'b1;
        m_result[wb_trans_id_i[p]] = wb_data_i[p];
      end
    end
    for (int e = 0; e < 8; e++) if (oi[e] && ofu[e] == NONE) m_valid[e] = 1'b1;
    for (int c = 0; c < nacks; c++) begin
      m_issued[(m_cp + c) % 8] = 1'b0;
      m_valid[(m_cp + c) % 8] = 1'b0;
    end
    committed += nacks;
    m_cnt = m_cnt + int'(alloc) - nacks;
    m_ip = (m_ip + int'(alloc)) % 8;
    m_cp = (m_cp + nacks) % 8;
    if (flush_i) begin
      for (int e = 0; e < 8; e++) begin
        m_issued[e] = 1'b0;
        m_valid[e] = 1'b0;
      end
      m_cnt = 0;
      m_ip = 0;
      m_cp = 0;
    end
  endtask

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------
  task automatic step();
    int cand [$];
    int k;
    @(posedge clk_i);
    model_update();
    if (auto_issue) begin
      s_dec_valid = $urandom_range(0, 3) != 0;
      s_fu = fu_e'($urandom_range(0, 4));
      // now and then an instruction that targets x0
      s_rd = ($urandom_range(0, 7) == 0) ? reg_addr_t'(0) : free_rd();
    end
    if (auto_wb) begin
      s_wb_valid = '0;
      for (int e = 0; e < 8; e++) begin
        if (m_issued[e] && !m_valid[e] && m_fu[e] != NONE) cand.push_back(e);
      end
      for (int p = 0; p < 2; p++) begin
        if (cand.size() > 0 && $urandom_range(0, 1)) begin
          k = $urandom_range(0, cand.size() - 1);
          s_wb_valid[p] = 1'b1;
          s_wb_id[p] = trans_id_t'(cand[k]);
          s_wb_data[p] = $urandom();
          cand.delete(k);
        end
      end
    end
    if (auto_ack) begin
      s_ack[0] = m_valid[m_cp] && $urandom_range(0, 2) != 0;
      s_ack[1] = s_ack[0] && m_valid[(m_cp + 1) % 8] && $urandom_range(0, 1);
    end
    if (auto_rs) begin
      s_rs1 = $urandom_range(0, 31);
      s_rs2 = m_rd[$urandom_range(0, 7)];
    end
    decoded_valid_i <= s_dec_valid;
    decoded_fu_i <= s_fu;
    decoded_rd_i <= s_rd;
    unresolved_branch_i <= s_branch;
    issue_ack_i <= s_dec_valid && !s_branch && m_cnt < 8;
    wb_valid_i <= s_wb_valid;
    wb_trans_id_i <= s_wb_id;
    wb_data_i <= s_wb_data;
    commit_ack_i <= s_ack;
    flush_i <= s_flush;
    flush_unissued_i <= s_flush_un;
    rs1_i <= s_rs1;
    rs2_i <= s_rs2;
    @(negedge clk_i);
  endtask

  task automatic quiet();
    {auto_issue, auto_wb, auto_ack, s_dec_valid, s_branch, s_flush, s_flush_un} = '0;
    s_wb_valid = '0;
    s_ack = '0;
    auto_rs = 1'b1;
  endtask

  task automatic timeout_fail(string what);
    $display("timeout in %s while waiting for %s", cur_test, what);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic mismatch(string what, longint exp, longint act);
    $display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    errors++;
  endtask

  // retire everything still in flight
  task automatic drain();
    int n;
    quiet();
    auto_wb = 1'b1;
    auto_ack = 1'b1;
    n = 0;
    while (m_cnt != 0) begin
      if (n++ > 200) timeout_fail("the queue to drain");
      step();
    end
    quiet();
    step();
  endtask

  task automatic finish_test(int err0);
    $display("test %s: %s (%0d errors)", cur_test, errors == err0 ? "pass" : "FAIL",
             errors - err0);
  endtask

  // ------------------------------------------------------------------
  // compare process runs every cycle outside reset
  // ------------------------------------------------------------------
  always @(negedge clk_i) begin
    logic [32:0] f;
    int s;
    if (rst_ni) begin
      if (sb_full_o !== (m_cnt == 8)) mismatch("full", m_cnt == 8, sb_full_o);
      if (issue_trans_id_o !== trans_id_t'(m_ip)) mismatch("issue id", m_ip, issue_trans_id_o);
      if (issue_valid_o !== (decoded_valid_i && !unresolved_branch_i && m_cnt < 8))
        mismatch("issue valid", !issue_valid_o, issue_valid_o);
      if (decoded_ack_o !== (issue_ack_i && m_cnt < 8))
        mismatch("decoded ack", !decoded_ack_o, decoded_ack_o);
      for (int c = 0; c < 2; c++) begin
        s = (m_cp + c) % 8;
        if (commit_valid_o[c] !== m_valid[s]) mismatch("commit valid", m_valid[s], commit_valid_o[c]);
        if (commit_trans_id_o[c] !== trans_id_t'(s)) mismatch("commit id", s, commit_trans_id_o[c]);
        if (m_valid[s] && commit_rd_o[c] !== m_rd[s]) mismatch("commit rd", m_rd[s], commit_rd_o[c]);
        if (m_valid[s] && commit_result_o[c] !== m_result[s])
          mismatch("commit result", m_result[s], commit_result_o[c]);
      end
      for (int r = 0; r < 32; r++) begin
        if (rd_clobber_o[r] !== expected_clobber(r))
          mismatch($sformatf("clobber x%0d", r), expected_clobber(r), rd_clobber_o[r]);
      end
      f = expected_fwd(rs1_i);
      if (rs1_valid_o !== f[32] || (f[32] && rs1_o !== f[31:0]))
        mismatch("rs1", f, {rs1_valid_o, rs1_o});
      f = expected_fwd(rs2_i);
      if (rs2_valid_o !== f[32] || (f[32] && rs2_o !== f[31:0]))
        mismatch("rs2", f, {rs2_valid_o, rs2_o});
    end
  end

  // ------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------
  initial begin
    int err0, n, slot_a, c0, ip0;
    reg_addr_t rd_a;
    xlen_t d;
    void'($urandom(32'ha5c3_f1d5));
    rst_ni <= 1'b0;
    {flush_i, flush_unissued_i, unresolved_branch_i, decoded_valid_i, issue_ack_i} <= '0;
    decoded_fu_i <= NONE;
    {decoded_rd_i, rs1_i, rs2_i, wb_valid_i, wb_trans_id_i, wb_data_i, commit_ack_i} <= '0;
    for (int e = 0; e < 8; e++) begin
      m_issued[e] = 1'b0;
      m_valid[e] = 1'b0;
      m_fu[e] = NONE;
      m_rd[e] = '0;
      m_result[e] = '0;
    end
    {m_ip, m_cp, m_cnt, committed, errors} = '0;
    s_wb_id = '0;
    s_wb_data = '0;
    s_fu = NONE;
    {s_rd, s_rs1, s_rs2} = '0;
    quiet();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    cur_test = "commit_order";
    err0 = errors;
    auto_issue = 1'b1;
    auto_wb = 1'b1;
    auto_ack = 1'b1;
    n = 0;
    while (committed < 60) begin
      if (n++ > 3000) timeout_fail("60 commits");
      step();
    end
    drain();
    finish_test(err0);

    cur_test = "back_pressure";
    err0 = errors;
    auto_issue = 1'b1;
    n = 0;
    while (m_cnt != 8) begin
      if (n++ > 200) timeout_fail("a full queue");
      step();
    end
    quiet();
    s_dec_valid = 1'b1;
    s_fu = ALU;
    step();
    if (sb_full_o !== 1'b1) mismatch("full flag", 1, sb_full_o);
    if (decoded_ack_o !== 1'b0 || issue_valid_o !== 1'b0)
      mismatch("ack and valid", 0, {decoded_ack_o, issue_valid_o});
    s_dec_valid = 1'b0;
    auto_wb = 1'b1;
    n = 0;
    while (!m_valid[m_cp]) begin
      if (n++ > 200) timeout_fail("the oldest entry to complete");
      step();
    end
    auto_wb = 1'b0;
    s_wb_valid = '0;
    s_ack = 2'b01;
    step();
    s_ack = 2'b00;
    s_dec_valid = 1'b1;
    s_branch = 1'b1;
    s_rd = free_rd();
    step();
    if (sb_full_o !== 1'b0) mismatch("full after commit", 0, sb_full_o);
    if (issue_valid_o !== 1'b0) mismatch("valid under branch", 0, issue_valid_o);
    s_branch = 1'b0;
    step();
    if (issue_valid_o !== 1'b1 || decoded_ack_o !== 1'b1)
      mismatch("accept after commit", 3, {issue_valid_o, decoded_ack_o});
    drain();
    finish_test(err0);

    cur_test = "clobber_map";
    err0 = errors;
    auto_issue = 1'b1;
    n = 0;
    while (m_cnt < 5) begin
      if (n++ > 200) timeout_fail("5 entries in flight");
      step();
    end
    quiet();
    step();
    for (int e = 0; e < 8; e++) begin
      if (m_issued[e] && m_rd[e] != 0 && rd_clobber_o[m_rd[e]] !== m_fu[e])
        mismatch("clobber of target", m_fu[e], rd_clobber_o[m_rd[e]]);
    end
    if (rd_clobber_o[0] !== NONE) mismatch("clobber x0", NONE, rd_clobber_o[0]);
    drain();
    for (int r = 0; r < 32; r++) begin
      if (rd_clobber_o[r] !== NONE) mismatch("clobber after commit", NONE, rd_clobber_o[r]);
    end
    finish_test(err0);

    cur_test = "forwarding";
    err0 = errors;
    slot_a = m_ip;
    rd_a = free_rd();
    s_dec_valid = 1'b1;
    s_fu = ALU;
    s_rd = rd_a;
    step();
    // the first instruction is not in the model yet
    do begin
      s_rd = free_rd();
    end while (s_rd == rd_a);
    step();
    s_dec_valid = 1'b0;
    auto_rs = 1'b0;
    s_rs1 = rd_a;
    s_rs2 = s_rd;
    step();
    if (rs2_valid_o !== 1'b0) mismatch("pending rs2 valid", 0, rs2_valid_o);
    d = $urandom();
    s_wb_valid = 2'b01;
    s_wb_id[0] = trans_id_t'(slot_a);
    s_wb_data[0] = d;
    step();
    if (rs1_valid_o !== 1'b1 || rs1_o !== d) mismatch("same-cycle write-back", d, rs1_o);
    s_wb_valid = 2'b00;
    step();
    if (rs1_valid_o !== 1'b1 || rs1_o !== d) mismatch("stored result", d, rs1_o);
    d = ~d;
    s_wb_valid = 2'b10;
    s_wb_id[1] = trans_id_t'(slot_a);
    s_wb_data[1] = d;
    step();
    if (rs1_valid_o !== 1'b1 || rs1_o !== d) mismatch("write-back over stored", d, rs1_o);
    s_wb_valid = 2'b00;
    // a completed entry on x0 must still not forward
    s_dec_valid = 1'b1;
    s_fu = NONE;
    s_rd = '0;
    step();
    s_dec_valid = 1'b0;
    s_rs1 = '0;
    step();
    step();
    if (rs1_valid_o !== 1'b0) mismatch("x0 valid", 0, rs1_valid_o);
    drain();
    finish_test(err0);

    cur_test = "flush_and_none";
    err0 = errors;
    c0 = committed;
    s_dec_valid = 1'b1;
    s_fu = NONE;
    s_rd = free_rd();
    step();
    s_dec_valid = 1'b0;
    auto_ack = 1'b1;
    n = 0;
    while (committed == c0) begin
      if (n++ > 20) timeout_fail("a NONE entry to commit");
      step();
    end
    quiet();
    ip0 = m_ip;
    s_dec_valid = 1'b1;
    s_flush_un = 1'b1;
    step();
    quiet();
    step();
    if (issue_trans_id_o !== trans_id_t'(ip0)) mismatch("id after flush_unissued", ip0,
                                                        issue_trans_id_o);
    auto_issue = 1'b1;
    auto_wb = 1'b1;
    repeat (6) step();
    quiet();
    step();
    s_flush = 1'b1;
    step();
    s_flush = 1'b0;
    step();
    if (commit_valid_o !== 2'b00) mismatch("commit valid after flush", 0, commit_valid_o);
    for (int r = 0; r < 32; r++) begin
      if (rd_clobber_o[r] !== NONE) mismatch("clobber after flush", NONE, rd_clobber_o[r]);
    end
    if (issue_trans_id_o !== '0) mismatch("id after flush", 0, issue_trans_id_o);
    finish_test(err0);

    $display("tests done, %0d errors, %0d entries committed", errors, committed);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: test/scoreboard_properties.sv
// concurrent checks on the scoreboard ports, attached to every scoreboard_top by bind
// failures show up only as assertion errors
`include "sb_params.svh"

module scoreboard_properties
  import sb_pkg::*;
(
  input logic                          clk_i,
  input logic                          rst_ni,
  input fu_e       [`SB_NR_REGS-1:0]   rd_clobber_o,
  input logic      [`SB_NR_COMMIT-1:0] commit_ack_i,
  input logic      [`SB_NR_COMMIT-1:0] commit_valid_o,
  input logic                          issue_ack_i,
  input logic                          issue_valid_o,
  input logic      [`SB_NR_WB-1:0]     wb_valid_i,
  input trans_id_t [`SB_NR_WB-1:0]     wb_trans_id_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // x0 is never written by a unit
  a_x0_clobber: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_o[0] == NONE) else $error("clobber of x0 is not NONE");

  // ack only on an entry that is ready to retire
  a_commit_ack0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i[0] |-> commit_valid_o[0]) else $error("commit ack 0 on invalid entry");
  a_commit_ack1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i[1] |-> (commit_valid_o[1] && commit_ack_i[0]))
    else $error("commit ack 1 without valid entry or ack 0");

  a_issue_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_valid_o) else $error("issue ack while issue valid is low");

  // two ports never write the same slot in one cycle
  a_wb_ids: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_valid_i[0] && wb_valid_i[1]) |-> (wb_trans_id_i[0] != wb_trans_id_i[1]))
    else $error("both write-back ports carry the same id");

endmodule

bind scoreboard_top scoreboard_properties u_props (.*);

// File: design/scoreboard_top.sv
// issue scoreboard top level, in-order issue with out-of-order completion
// gates issue on branch and full state and ties queue, clobber map and forwarder together
`include "sb_params.svh"

module scoreboard_top
  import sb_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  output logic                              sb_full_o,
  input  logic                              flush_i,
  input  logic                              flush_unissued_i,
  input  logic                              unresolved_branch_i,
  // decoded instruction from the front end
  input  logic                              decoded_valid_i,
  input  fu_e                               decoded_fu_i,
  input  reg_addr_t                         decoded_rd_i,
  output logic                              decoded_ack_o,
  // issue handshake
  output logic                              issue_valid_o,
  output trans_id_t                         issue_trans_id_o,
  input  logic                              issue_ack_i,
  // write-back ports
  input  logic      [`SB_NR_WB-1:0]         wb_valid_i,
  input  trans_id_t [`SB_NR_WB-1:0]         wb_trans_id_i,
  input  xlen_t     [`SB_NR_WB-1:0]         wb_data_i,
  // commit ports
  output logic      [`SB_NR_COMMIT-1:0]     commit_valid_o,
  output reg_addr_t [`SB_NR_COMMIT-1:0]     commit_rd_o,
  output xlen_t     [`SB_NR_COMMIT-1:0]     commit_result_o,
  output trans_id_t [`SB_NR_COMMIT-1:0]     commit_trans_id_o,
  input  logic      [`SB_NR_COMMIT-1:0]     commit_ack_i,
  // clobber map to the issue stage
  output fu_e       [`SB_NR_REGS-1:0]       rd_clobber_o,
  // operand read ports
  input  reg_addr_t                         rs1_i,
  output xlen_t                             rs1_o,
  output logic                              rs1_valid_o,
  input  reg_addr_t                         rs2_i,
  output xlen_t                             rs2_o,
  output logic                              rs2_valid_o
);

  logic                             alloc;
  logic      [`SB_NR_ENTRIES-1:0]   ent_issued;
  logic      [`SB_NR_ENTRIES-1:0]   ent_valid;
  fu_e       [`SB_NR_ENTRIES-1:0]   ent_fu;
  reg_addr_t [`SB_NR_ENTRIES-1:0]   ent_rd;
  xlen_t     [`SB_NR_ENTRIES-1:0]   ent_result;

  // ------------------------------------------------------------------
  // issue gating
  // ------------------------------------------------------------------
  // no issue behind an unresolved branch or into a full queue
  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~sb_full_o;
  assign decoded_ack_o = issue_ack_i & ~sb_full_o;
  // flush_unissued kills the instruction on its way in
  assign alloc         = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;

  sb_entry_queue u_queue (
    .clk_i, .rst_ni,
    .alloc_i           (alloc),
    .alloc_fu_i        (decoded_fu_i),
    .alloc_rd_i        (decoded_rd_i),
    .wb_valid_i, .wb_trans_id_i, .wb_data_i,
    .commit_ack_i, .flush_i,
    .full_o            (sb_full_o),
    .issue_ptr_o       (issue_trans_id_o),
    .ent_issued_o      (ent_issued),
    .ent_valid_o       (ent_valid),
    .ent_fu_o          (ent_fu),
    .ent_rd_o          (ent_rd),
    .ent_result_o      (ent_result),
    .commit_valid_o, .commit_rd_o, .commit_result_o, .commit_trans_id_o
  );

  // clobber map and forwarder look at the same queue snapshot
  sb_clobber_map u_clobber (
    .ent_issued_i (ent_issued),
    .ent_fu_i     (ent_fu),
    .ent_rd_i     (ent_rd),
    .rd_clobber_o
  );

  sb_operand_fwd u_fwd (
    .rs1_i, .rs2_i,
    .wb_valid_i, .wb_trans_id_i, .wb_data_i,
    .ent_issued_i (ent_issued),
    .ent_valid_i  (ent_valid),
    .ent_rd_i     (ent_rd),
    .ent_result_i (ent_result),
    .rs1_o, .rs1_valid_o, .rs2_o, .rs2_valid_o
  );

endmodule

// File: design/sb_operand_fwd.sv
// source operand forwarding for rs1 and rs2
// same-cycle write-backs first, then completed entries still in the queue
`include "sb_params.svh"

module sb_operand_fwd
  import sb_pkg::*;
(
  input  reg_addr_t                      rs1_i,
  input  reg_addr_t                      rs2_i,
  // write-back ports, tapped in the same cycle
  input  logic      [`SB_NR_WB-1:0]      wb_valid_i,
  input  trans_id_t [`SB_NR_WB-1:0]      wb_trans_id_i,
  input  xlen_t     [`SB_NR_WB-1:0]      wb_data_i,
  // queue contents
  input  logic      [`SB_NR_ENTRIES-1:0] ent_issued_i,
  input  logic      [`SB_NR_ENTRIES-1:0] ent_valid_i,
  input  reg_addr_t [`SB_NR_ENTRIES-1:0] ent_rd_i,
  input  xlen_t     [`SB_NR_ENTRIES-1:0] ent_result_i,
  // forwarded operands
  output xlen_t                          rs1_o,
  output logic                           rs1_valid_o,
  output xlen_t                          rs2_o,
  output logic                           rs2_valid_o
);

  // write-back ports sit at the low indices and so win the selection
  localparam int unsigned NUM_IN = `SB_NR_WB + `SB_NR_ENTRIES;

  logic [NUM_IN-1:0] rs1_req;
  logic [NUM_IN-1:0] rs2_req;
  xlen_t             fwd_data [NUM_IN];
  logic              rs1_hit;
  logic              rs2_hit;

  // ------------------------------------------------------------------
  // request vectors
  // ------------------------------------------------------------------
  always_comb begin
    // a strobe counts only when its slot still holds an issued entry
    for (int p = 0; p < `SB_NR_WB; p++) begin
      rs1_req[p]  = wb_valid_i[p] && ent_issued_i[wb_trans_id_i[p]] &&
                    (ent_rd_i[wb_trans_id_i[p]] == rs1_i);
      rs2_req[p]  = wb_valid_i[p] && ent_issued_i[wb_trans_id_i[p]] &&
                    (ent_rd_i[wb_trans_id_i[p]] == rs2_i);
      fwd_data[p] = wb_data_i[p];
    end
    // stored entries only once their result is in
    for (int e = 0; e < `SB_NR_ENTRIES; e++) begin
      rs1_req[`SB_NR_WB+e]  = ent_issued_i[e] && ent_valid_i[e] && (ent_rd_i[e] == rs1_i);
      rs2_req[`SB_NR_WB+e]  = ent_issued_i[e] && ent_valid_i[e] && (ent_rd_i[e] == rs2_i);
      fwd_data[`SB_NR_WB+e] = ent_result_i[e];
    end
  end

  // ------------------------------------------------------------------
  // selection
  // ------------------------------------------------------------------
  sb_prio_select #(.NUM_IN(NUM_IN), .payload_t(xlen_t)) u_sel_rs1 (
    .req_i   (rs1_req),
    .data_i  (fwd_data),
    .valid_o (rs1_hit),
    .data_o  (rs1_o)
  );

  sb_prio_select #(.NUM_IN(NUM_IN), .payload_t(xlen_t)) u_sel_rs2 (
    .req_i   (rs2_req),
    .data_i  (fwd_data),
    .valid_o (rs2_hit),
    .data_o  (rs2_o)
  );

  // x0 reads come from the register file, never from here
  assign rs1_valid_o = rs1_hit && (rs1_i != '0);
  assign rs2_valid_o = rs2_hit && (rs2_i != '0);

endmodule

// File: design/sb_clobber_map.sv
// clobber map, tells the issue stage which unit will write each register
// one priority selector per register over all issued entries
`include "sb_params.svh"

module sb_clobber_map
  import sb_pkg::*;
(
  input  logic      [`SB_NR_ENTRIES-1:0] ent_issued_i,
  input  fu_e       [`SB_NR_ENTRIES-1:0] ent_fu_i,
  input  reg_addr_t [`SB_NR_ENTRIES-1:0] ent_rd_i,
  output fu_e       [`SB_NR_REGS-1:0]    rd_clobber_o
);

  localparam int unsigned NUM_IN = `SB_NR_ENTRIES + 1;

  // candidates, one per entry plus the NONE default in the last slot
  fu_e cand_fu [NUM_IN];

  always_comb begin
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      cand_fu[i] = ent_fu_i[i];
    end
    // lowest priority, shown when no entry targets the register
    cand_fu[`SB_NR_ENTRIES] = NONE;
  end

  // ------------------------------------------------------------------
  // per-register lookup
  // ------------------------------------------------------------------
  for (genvar r = 0; r < `SB_NR_REGS; r++) begin : gen_reg
    logic [NUM_IN-1:0] req;

    always_comb begin
      // x0 is never clobbered, only the default may request there
      for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
        req[i] = ent_issued_i[i] && (ent_rd_i[i] == reg_addr_t'(r)) && (r != 0);
      end
      req[`SB_NR_ENTRIES] = 1'b1;
    end

    // the default always requests, so the valid flag carries no news
    sb_prio_select #(
      .NUM_IN    (NUM_IN),
      .payload_t (fu_e)
    ) u_sel (
      .req_i   (req),
      .data_i  (cand_fu),
      .valid_o (),
      .data_o  (rd_clobber_o[r])
    );
  end

endmodule

// File: design/sb_entry_queue.sv
// circular entry queue of the scoreboard, slot index is the transaction id
// holds per-entry state and the issue and commit pointers, shows the two oldest entries
`include "sb_params.svh"

module sb_entry_queue
  import sb_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // allocation of a new entry at the issue pointer
  input  logic                                alloc_i,
  input  fu_e                                 alloc_fu_i,
  input  reg_addr_t                           alloc_rd_i,
  // write-back ports
  input  logic      [`SB_NR_WB-1:0]           wb_valid_i,
  input  trans_id_t [`SB_NR_WB-1:0]           wb_trans_id_i,
  input  xlen_t     [`SB_NR_WB-1:0]           wb_data_i,
  // commit and flush
  input  logic      [`SB_NR_COMMIT-1:0]       commit_ack_i,
  input  logic                                flush_i,
  // occupancy
  output logic                                full_o,
  output trans_id_t                           issue_ptr_o,
  // per-entry view for the clobber map and the forwarder
  output logic      [`SB_NR_ENTRIES-1:0]      ent_issued_o,
  output logic      [`SB_NR_ENTRIES-1:0]      ent_valid_o,
  output fu_e       [`SB_NR_ENTRIES-1:0]      ent_fu_o,
  output reg_addr_t [`SB_NR_ENTRIES-1:0]      ent_rd_o,
  output xlen_t     [`SB_NR_ENTRIES-1:0]      ent_result_o,
  // commit ports, port 0 is the oldest entry
  output logic      [`SB_NR_COMMIT-1:0]       commit_valid_o,
  output reg_addr_t [`SB_NR_COMMIT-1:0]       commit_rd_o,
  output xlen_t     [`SB_NR_COMMIT-1:0]       commit_result_o,
  output trans_id_t [`SB_NR_COMMIT-1:0]       commit_trans_id_o
);

  localparam int unsigned IDX_W = $clog2(`SB_NR_ENTRIES);
  localparam int unsigned CNT_W = IDX_W + 1;

  // control state
  logic [`SB_NR_ENTRIES-1:0] issued_q, issued_d;
  logic [`SB_NR_ENTRIES-1:0] valid_q, valid_d;
  trans_id_t                 issue_ptr_q, issue_ptr_d;
  trans_id_t                 commit_ptr_q, commit_ptr_d;
  logic [CNT_W-1:0]          cnt_q, cnt_d;

  // payload
  fu_e       [`SB_NR_ENTRIES-1:0] fu_q, fu_d;
  reg_addr_t [`SB_NR_ENTRIES-1:0] rd_q, rd_d;
  xlen_t     [`SB_NR_ENTRIES-1:0] result_q, result_d;

  // slot behind each commit port
  trans_id_t commit_ptr [`SB_NR_COMMIT];
  // number of entries retired this cycle, 0 to 2
  logic [1:0] num_commit;

  // counter top bit set means all slots are taken
  assign full_o      = cnt_q[IDX_W];
  assign issue_ptr_o = issue_ptr_q;

  always_comb begin
    for (int c = 0; c < `SB_NR_COMMIT; c++) begin
      commit_ptr[c] = commit_ptr_q + trans_id_t'(c);
    end
  end

  // ack bit 1 only comes together with bit 0
  assign num_commit = {1'b0, commit_ack_i[0]} + {1'b0, commit_ack_i[1]};

  // ------------------------------------------------------------------
  // entry update
  // ------------------------------------------------------------------
  // later sections win: alloc, write-back, unit NONE, commit, flush
  always_comb begin
    issued_d = issued_q;
    valid_d  = valid_q;
    fu_d     = fu_q;
    rd_d     = rd_q;
    result_d = result_q;

    // new entry, issued but still waiting for its result
    if (alloc_i) begin
      issued_d[issue_ptr_q] = 1'b1;
      valid_d[issue_ptr_q]  = 1'b0;
      fu_d[issue_ptr_q]     = alloc_fu_i;
      rd_d[issue_ptr_q]     = alloc_rd_i;
    end

    // write-back, dropped when nothing is issued in that slot
    // (a late result from before a flush)
    for (int p = 0; p < `SB_NR_WB; p++) begin
      if (wb_valid_i[p] && issued_q[wb_trans_id_i[p]]) begin
        valid_d[wb_trans_id_i[p]]  = 1'b1;
        result_d[wb_trans_id_i[p]] = wb_data_i[p];
      end
    end

    // no unit behind the entry, it completes on its own
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (issued_q[i] && (fu_q[i] == NONE)) begin
        valid_d[i] = 1'b1;
      end
    end

    // retired entries leave the queue
    for (int c = 0; c < `SB_NR_COMMIT; c++) begin
      if (commit_ack_i[c]) begin
        issued_d[commit_ptr[c]] = 1'b0;
        valid_d[commit_ptr[c]]  = 1'b0;
      end
    end

    // full flush drops everything in flight
    if (flush_i) begin
      issued_d = '0;
      valid_d  = '0;
    end
  end

  // ------------------------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------------------------
  assign cnt_d        = flush_i ? '0 :
                        cnt_q - CNT_W'(num_commit) + CNT_W'(alloc_i);
  assign issue_ptr_d  = flush_i ? '0 : issue_ptr_q + trans_id_t'(alloc_i);
  assign commit_ptr_d = flush_i ? '0 : commit_ptr_q + trans_id_t'(num_commit);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q     <= '0;
      valid_q      <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issued_q     <= issued_d;
      valid_q      <= valid_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      cnt_q        <= cnt_d;
    end
  end

  // payload only matters while the issued bit is set
  always_ff @(posedge clk_i) begin
    fu_q     <= fu_d;
    rd_q     <= rd_d;
    result_q <= result_d;
  end

  // ------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------
  assign ent_issued_o = issued_q;
  assign ent_valid_o  = valid_q;
  assign ent_fu_o     = fu_q;
  assign ent_rd_o     = rd_q;
  assign ent_result_o = result_q;

  always_comb begin
    for (int c = 0; c < `SB_NR_COMMIT; c++) begin
      commit_valid_o[c]    = valid_q[commit_ptr[c]];
      commit_rd_o[c]       = rd_q[commit_ptr[c]];
      commit_result_o[c]   = result_q[commit_ptr[c]];
      commit_trans_id_o[c] = commit_ptr[c];
    end
  end

endmodule

// File: design/sb_prio_select.sv
// fixed-priority selector, the lowest requesting index wins
// shared by the clobber map (unit payload) and the operand forwarder (data payload)
module sb_prio_select
  import sb_pkg::*;
#(
  parameter int unsigned NUM_IN = 4,
  parameter type payload_t = xlen_t
) (
  input  logic [NUM_IN-1:0] req_i,
  input  payload_t          data_i [NUM_IN],
  output logic              valid_o,
  output payload_t          data_o
);

  // ------------------------------------------------------------------
  // priority scan
  // ------------------------------------------------------------------
  // walk from the highest index down so that a lower request overwrites
  // whatever a higher one picked before it
  always_comb begin
    valid_o = 1'b0;
    // with no request the last input is shown, valid_o stays low
    data_o  = data_i[NUM_IN-1];
    for (int i = int'(NUM_IN) - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        valid_o = 1'b1;
        data_o  = data_i[i];
      end
    end
  end

  // note: only one request is expected per lookup in normal operation,
  // the priority just makes the choice deterministic when that breaks
  // (for instance right after a flush with units still writing back)

  // the selector holds no state

endmodule

// File: design/sb_pkg.sv
// shared types of the issue scoreboard
// modules pull these in with a wildcard import in their header
`include "sb_params.svh"

package sb_pkg;

  // ------------------------------------------------------------------
  // functional unit that will produce the result of an entry
  // ------------------------------------------------------------------
  // NONE means the entry completes by itself, without a write-back
  typedef enum logic [`SB_FU_W-1:0] {
    NONE  = 0,
    ALU   = 1,
    MULT  = 2,
    LOAD  = 3,
    STORE = 4
  } fu_e;

  // ------------------------------------------------------------------
  // scalar types
  // ------------------------------------------------------------------
  // integer register index
  typedef logic [`SB_REG_ADDR_W-1:0] reg_addr_t;

  // result and operand word
  typedef logic [`SB_XLEN-1:0] xlen_t;

  // transaction id, equal to the queue slot of the entry
  typedef logic [`SB_TRANS_ID_W-1:0] trans_id_t;

endpackage

// File: include/sb_params.svh
// sizing macros for the issue scoreboard
// included by the package and by every module that sizes ports or storage
`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// queue depth, must stay a power of two so the counter top bit reads as full
`define SB_NR_ENTRIES 8
// write-back ports from the functional units
`define SB_NR_WB 2
// integer register file size
`define SB_NR_REGS 32
// data path width
`define SB_XLEN 32
// commit ports, the commit logic assumes exactly two
`define SB_NR_COMMIT 2

// field widths
`define SB_REG_ADDR_W 5
`define SB_TRANS_ID_W 3
`define SB_FU_W 3

`endif
